//--- common/fft_macros.svh
`ifndef FFT_MACROS_SVH
`define FFT_MACROS_SVH

// frame size and stage count
`define FFT_POINTS 16
`define FFT_STAGES 2

// sample word, two signed halves
`define SAMPLE_W 22
`define COMP_W 11

// twiddle format, Q0.9
`define TW_W 10
`define TW_FRAC 9

// cycles from bf_start to bf_done
`define BF_LATENCY 3

`endif

//--- common/fft_pkg.sv
`include "fft_macros.svh"

package fft_pkg;

   typedef struct packed {
      logic signed [`COMP_W-1:0] re;   // upper half
      logic signed [`COMP_W-1:0] im;
   } complex_t;

   // store keeps the raw word, butterfly works on the halves
   typedef union packed {
      logic [`SAMPLE_W-1:0] raw;
      complex_t             c;
   } sample_u;

   typedef logic [$clog2(`FFT_POINTS)-1:0] index_t;

   typedef logic stage_t;

   typedef logic [1:0] tw_step_t;   // butterfly position in stage 0

   typedef logic [3:0] tw_exp_t;   // W16 exponent

endpackage

//--- butterfly/twiddle_rom.sv
`timescale 1ns/100ps
`include "fft_macros.svh"

module twiddle_rom (
   input  fft_pkg::tw_exp_t  exp,
   output fft_pkg::complex_t w
);

   logic signed [`TW_W-1:0] w_re;
   logic signed [`TW_W-1:0] w_im;

   // round(512*cos), round(-512*sin), 1.0 clipped to 511
   always_comb begin
      case (exp)
         4'd0: {w_re, w_im} = {10'sd511, 10'sd0};
         4'd1: {w_re, w_im} = {10'sd473, -10'sd196};
         4'd2: {w_re, w_im} = {10'sd362, -10'sd362};
         4'd3: {w_re, w_im} = {10'sd196, -10'sd473};
         4'd4: {w_re, w_im} = {10'sd0, -10'sd512};
         4'd5: {w_re, w_im} = {-10'sd196, -10'sd473};
         4'd6: {w_re, w_im} = {-10'sd362, -10'sd362};
         4'd7: {w_re, w_im} = {-10'sd473, -10'sd196};
         4'd8: {w_re, w_im} = {-10'sd512, 10'sd0};
         4'd9: {w_re, w_im} = {-10'sd473, 10'sd196};
         default: {w_re, w_im} = '0;   // exponent never above 9
      endcase
   end

   assign w.re = w_re;   // sign extends into the sample half
   assign w.im = w_im;

endmodule

//--- butterfly/radix4_butterfly.sv
`timescale 1ns/100ps
`include "fft_macros.svh"

module radix4_butterfly (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   bf_start,
   input  fft_pkg::sample_u [3:0] x,
   input  fft_pkg::tw_step_t      tw_step,
   output fft_pkg::sample_u [3:0] y,
   output logic                   bf_done
);

   logic [`BF_LATENCY-1:0]    vld;
   fft_pkg::complex_t [3:0]   a_r;   // captured operands
   fft_pkg::tw_step_t         step_r;
   fft_pkg::tw_step_t         step_s;
   fft_pkg::complex_t [3:0]   s_r;   // scaled DFT-4 sums
   fft_pkg::complex_t [3:0]   w;
   logic signed [`COMP_W+1:0] sum_re [4];
   logic signed [`COMP_W+1:0] sum_im [4];

   function automatic fft_pkg::complex_t cmul(input fft_pkg::complex_t z,
                                              input fft_pkg::complex_t t);
      logic signed [2*`COMP_W:0] prod_re;
      logic signed [2*`COMP_W:0] prod_im;
      fft_pkg::complex_t         r;
      prod_re = z.re * t.re - z.im * t.im;
      prod_im = z.re * t.im + z.im * t.re;
      r.re    = prod_re[`TW_FRAC+`COMP_W-1:`TW_FRAC];   // >>> TW_FRAC
      r.im    = prod_im[`TW_FRAC+`COMP_W-1:`TW_FRAC];
      return r;
   endfunction

   assign w[0] = '{re: (1 << `TW_FRAC) - 1, im: '0};   // W^0

   for (genvar m = 1; m < 4; m++) begin : g_rom
      twiddle_rom u_rom (
         .exp (fft_pkg::tw_exp_t'(m * step_s)),
         .w   (w[m])
      );
   end

   // x_n * (-j)^(n*m)
   always_comb begin
      sum_re[0] = a_r[0].re + a_r[1].re + a_r[2].re + a_r[3].re;
      sum_im[0] = a_r[0].im + a_r[1].im + a_r[2].im + a_r[3].im;
      sum_re[1] = a_r[0].re + a_r[1].im - a_r[2].re - a_r[3].im;
      sum_im[1] = a_r[0].im - a_r[1].re - a_r[2].im + a_r[3].re;
      sum_re[2] = a_r[0].re - a_r[1].re + a_r[2].re - a_r[3].re;
      sum_im[2] = a_r[0].im - a_r[1].im + a_r[2].im - a_r[3].im;
      sum_re[3] = a_r[0].re - a_r[1].im - a_r[2].re + a_r[3].im;
      sum_im[3] = a_r[0].im + a_r[1].re - a_r[2].im - a_r[3].re;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         vld <= '0;
      end else begin
         vld <= {vld[`BF_LATENCY-2:0], bf_start};
      end
   end

   always_ff @(posedge clk) begin
      if (bf_start) begin
         for (int m = 0; m < 4; m++) begin
            a_r[m] <= x[m].c;
         end
         step_r <= tw_step;
      end
      if (vld[0]) begin
         for (int m = 0; m < 4; m++) begin
            s_r[m].re <= sum_re[m][`COMP_W+1:2];   // >>> 2
            s_r[m].im <= sum_im[m][`COMP_W+1:2];
         end
         step_s <= step_r;
      end
      if (vld[1]) begin
         for (int m = 0; m < 4; m++) begin
            y[m].c <= cmul(s_r[m], w[m]);
         end
      end
   end

   assign bf_done = vld[`BF_LATENCY-1];

endmodule

//--- src/fft_ctrl.sv
`timescale 1ns/100ps
`include "fft_macros.svh"

module fft_ctrl (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start,
   input  logic                  bf_done,
   output logic                  capture,
   output logic                  bf_start,
   output fft_pkg::index_t [3:0] rd_idx,
   output fft_pkg::tw_step_t     tw_step,
   output logic                  final_stage,
   output logic                  valid
);

   logic            busy;
   fft_pkg::stage_t stage;
   logic [1:0]      bf_cnt;   // butterfly within stage
   logic            last_bf;

   assign capture     = start && !busy;   // start ignored while busy
   assign final_stage = (stage == fft_pkg::stage_t'(`FFT_STAGES - 1));
   assign last_bf     = final_stage && (bf_cnt == 2'd3);

   // twiddles only apply between the two stages
   assign tw_step = final_stage ? '0 : bf_cnt;

   // stage 0 takes stride-4 points, stage 1 takes contiguous groups
   always_comb begin
      for (int m = 0; m < 4; m++) begin
         if (final_stage) begin
            rd_idx[m] = {bf_cnt, 2'(m)};
         end else begin
            rd_idx[m] = {2'(m), bf_cnt};
         end
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         busy     <= 1'b0;
         stage    <= '0;
         bf_cnt   <= '0;
         bf_start <= 1'b0;
         valid    <= 1'b0;
      end else begin
         bf_start <= 1'b0;
         valid    <= 1'b0;
         if (capture) begin
            busy     <= 1'b1;
            stage    <= '0;
            bf_cnt   <= '0;
            bf_start <= 1'b1;   // store is loaded on this edge
         end else if (bf_done) begin
            if (last_bf) begin
               busy  <= 1'b0;
               valid <= 1'b1;   // after the eighth writeback
            end else begin
               bf_cnt   <= bf_cnt + 2'd1;
               bf_start <= 1'b1;
               if (bf_cnt == 2'd3) begin
                  stage <= stage + 1'b1;
               end
            end
         end
      end
   end

endmodule

//--- src/fft_buffer.sv
`timescale 1ns/100ps
`include "fft_macros.svh"

module fft_buffer (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               capture,
   input  fft_pkg::sample_u [`FFT_POINTS-1:0] sample_in,
   input  fft_pkg::index_t [3:0]              rd_idx,
   input  logic                               bf_done,
   input  logic                               final_stage,
   input  fft_pkg::sample_u [3:0]             y,
   output fft_pkg::sample_u [3:0]             x,
   output fft_pkg::sample_u [`FFT_POINTS-1:0] sample_out
);

   logic [`SAMPLE_W-1:0] store [`FFT_POINTS];   // working store

   // swap the two base-4 digits of a point index
   function automatic fft_pkg::index_t digit_rev(input fft_pkg::index_t i);
      return {i[1:0], i[3:2]};
   endfunction

   always_comb begin
      for (int m = 0; m < 4; m++) begin
         x[m].raw = store[rd_idx[m]];
      end
   end

   // results go back in place, rd_idx still holds the issue indices
   always_ff @(posedge clk) begin
      if (capture) begin
         for (int n = 0; n < `FFT_POINTS; n++) begin
            store[n] <= sample_in[n].raw;
         end
      end else if (bf_done && !final_stage) begin
         for (int m = 0; m < 4; m++) begin
            store[rd_idx[m]] <= y[m].raw;
         end
      end
   end

   // final stage lands in natural order
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         sample_out <= '0;
      end else if (bf_done && final_stage) begin
         for (int m = 0; m < 4; m++) begin
            sample_out[digit_rev(rd_idx[m])] <= y[m];   // result m of g to 4m+g
         end
      end
   end

endmodule

//--- src/fft_top.sv
`timescale 1ns/100ps
`include "fft_macros.svh"

module fft_top (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 start,
   input  fft_pkg::sample_u [`FFT_POINTS-1:0]   sample_in,
   output fft_pkg::sample_u [`FFT_POINTS-1:0]   sample_out,
   output logic                                 valid
);

   logic                   capture;
   logic                   bf_start;
   logic                   bf_done;
   logic                   final_stage;
   fft_pkg::index_t [3:0]  rd_idx;
   fft_pkg::tw_step_t      tw_step;
   fft_pkg::sample_u [3:0] x;   // gathered operands
   fft_pkg::sample_u [3:0] y;   // butterfly results

   fft_ctrl u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .bf_done     (bf_done),
      .capture     (capture),
      .bf_start    (bf_start),
      .rd_idx      (rd_idx),
      .tw_step     (tw_step),
      .final_stage (final_stage),
      .valid       (valid)
   );

   fft_buffer u_buffer (
      .clk         (clk),
      .rst         (rst),
      .capture     (capture),
      .sample_in   (sample_in),
      .rd_idx      (rd_idx),
      .bf_done     (bf_done),
      .final_stage (final_stage),
      .y           (y),
      .x           (x),
      .sample_out  (sample_out)
   );

   radix4_butterfly u_bf (
      .clk      (clk),
      .rst      (rst),
      .bf_start (bf_start),
      .x        (x),
      .tw_step  (tw_step),
      .y        (y),
      .bf_done  (bf_done)
   );

endmodule

//--- verif/fft_assertions.sv
`timescale 1ns/100ps
`include "fft_macros.svh"

module fft_assertions (
   input logic clk,
   input logic rst,
   input logic bf_start,
   input logic bf_done,
   input logic valid,
   input logic capture
);

   logic in_frame;   // from capture up to its closing valid

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         in_frame <= 1'b0;
      end else if (capture) begin
         in_frame <= 1'b1;
      end else if (valid) begin
         in_frame <= 1'b0;
      end
   end

   // done strobe tracks the start strobe through the pipeline
   property p_bf_latency;
      @(posedge clk) disable iff (!rst)
         bf_done == $past(bf_start, `BF_LATENCY);
   endproperty

   property p_valid_pulse;
      @(posedge clk) disable iff (!rst)
         valid |=> !valid;
   endproperty

   // a new frame only once the previous one has closed
   property p_no_capture_busy;
      @(posedge clk) disable iff (!rst)
         capture |-> (!in_frame || valid);
   endproperty

   a_bf_latency: assert property (p_bf_latency)
      else $error("bf_done is not %0d cycles after bf_start", `BF_LATENCY);

   a_valid_pulse: assert property (p_valid_pulse)
      else $error("valid is high for more than one cycle");

   a_no_capture_busy: assert property (p_no_capture_busy)
      else $error("capture while a frame is running");

endmodule

//--- verif/fft_tb.sv
`timescale 1ns/100ps
`include "fft_macros.svh"

module fft_tb;

   localparam int FRAME_WORDS   = 2 * `FFT_POINTS;   // inputs then expected outputs
   localparam int VEC_WORDS     = 2 * FRAME_WORDS;
   localparam int VALID_TIMEOUT = 200;

   logic                               clk;
   logic                               rst;
   logic                               start;
   fft_pkg::sample_u [`FFT_POINTS-1:0] sample_in;
   fft_pkg::sample_u [`FFT_POINTS-1:0] sample_out;
   logic                               valid;

   logic [`SAMPLE_W-1:0] vectors [VEC_WORDS];
   logic [31:0]          lfsr;

   fft_top UUT (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .sample_in  (sample_in),
      .sample_out (sample_out),
      .valid      (valid)
   );

   bind fft_ctrl fft_assertions u_assertions (
      .clk      (clk),
      .rst      (rst),
      .bf_start (bf_start),
      .bf_done  (bf_done),
      .valid    (valid),
      .capture  (capture)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val  = {val[30:0], lfsr[0]};   // one step per bit
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_sample(input string name, input fft_pkg::sample_u got,
                               input fft_pkg::sample_u exp);
      if (got.raw !== exp.raw) begin
         report_failure($sformatf("mismatch %s: got %h expected %h", name, got.raw, exp.raw));
      end
   endtask

   task automatic check_valid(input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch valid: got %h expected %h", got, exp));
      end
   endtask

   task automatic check_outputs(input int frame);
      fft_pkg::sample_u e;
      for (int n = 0; n < `FFT_POINTS; n++) begin
         e.raw = vectors[frame * FRAME_WORDS + `FFT_POINTS + n];
         check_sample($sformatf("sample_out[%0d]", n), sample_out[n], e);
      end
   endtask

   task automatic scramble_inputs();
      logic [31:0] r;
      for (int n = 0; n < `FFT_POINTS; n++) begin
         rand_bits(`SAMPLE_W, r);
         sample_in[n].raw <= r[`SAMPLE_W-1:0];
      end
   endtask

   task automatic start_frame(input int frame);
      @(posedge clk);
      for (int n = 0; n < `FFT_POINTS; n++) begin
         sample_in[n].raw <= vectors[frame * FRAME_WORDS + n];
      end
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      scramble_inputs();   // already captured by now
   endtask

   // extra start strobes while the frame is running
   task automatic busy_pulses(input int n);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
         rand_bits(1, r);
         start <= r[0];
         @(negedge clk);
         check_valid(valid, 1'b0);
      end
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic wait_for_valid();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (valid !== 1'b1) begin
         cycles++;
         if (cycles >= VALID_TIMEOUT) begin
            report_failure("timeout while waiting for valid");
         end
         @(negedge clk);
      end
   endtask

   task automatic idle_cycles(input int n, input logic hold, input int frame);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         check_valid(valid, 1'b0);
         if (hold) begin
            check_outputs(frame);   // results held until the next frame
         end
      end
   endtask

   initial begin
      logic [31:0] r;
      rst       = 1'b0;
      start     = 1'b0;
      sample_in = '0;
      lfsr      = 32'h180d5f35;
      $readmemh("verif/fft_vectors.txt", vectors);
      for (int i = 0; i < VEC_WORDS; i++) begin
         if ($isunknown(vectors[i])) begin
            report_failure("vector file is missing or too short");
         end
      end
      repeat (3) @(posedge clk);
      rst <= 1'b1;

      rand_bits(3, r);
      idle_cycles(4 + int'(r), 1'b0, 0);   // no valid without start

      start_frame(0);
      busy_pulses(16);
      wait_for_valid();
      check_outputs(0);

      rand_bits(4, r);
      idle_cycles(2 + int'(r), 1'b1, 0);

      start_frame(1);
      wait_for_valid();
      check_outputs(1);
      idle_cycles(8, 1'b1, 1);

      $display(">>> PASS");
      $finish;
   end

endmodule

//--- verif/fft_vectors.txt
// two frames of 32 words: 16 input samples, then 16 expected outputs in natural order
// each word is {re[10:0], im[10:0]} in hex, two's complement halves
000000
0c9762
000000
000000
000000
000000
000000
000000
000000
000000
000000
000000
000000
000000
000000
000000
00bff6
0097ed
004fe7
0007e5
3fb7e7
3f6fec
3f3ff5
3f2fff
3f3809
3f6012
3fa817
3ff81a
004817
009012
00b809
00d000
36a078
000000
000000
000000
000000
0640fa
000000
000000
000000
000000
000000
000000
000000
000000
000000
000000
3fc815
3fb7f5
3ec803
3f9019
3fe7fb
3edffd
3f501a
000000
3f0ff8
3f1817
000008
3f3ff4
3ef012
3ff00f
3f7ff3
3ed00b

//--- src.f
+incdir+common
common/fft_pkg.sv
butterfly/twiddle_rom.sv
butterfly/radix4_butterfly.sv
src/fft_ctrl.sv
src/fft_buffer.sv
src/fft_top.sv
verif/fft_assertions.sv
verif/fft_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fft_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx '>>> PASS' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
